// ==== design/ctrl_decode.sv ====
////////////////////////////////////////
// Registered instruction decoder.
// Turns each ROM word into flow, Y address and load
// strobes, adds the second cycle of two-cycle words
// and loop boundaries, and flags bad opcodes.
////////////////////////////////////////
module ctrl_decode #(
    parameter int ni_w = 4,
    parameter int k_w  = 7
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [dsp16_ctrl_pkg::instr_w-1:0] instr,
    input  logic                               con_result,
    input  logic                               irq_take,
    input  logic                               do_busy,
    input  logic                               do_first_end,
    input  logic                               do_out,
    output dsp16_ctrl_pkg::instr_fields_t      fields,
    output dsp16_ctrl_pkg::flow_ctrl_t         flow,
    output dsp16_ctrl_pkg::yaau_ctrl_t         yaau,
    output dsp16_ctrl_pkg::load_ctrl_t         load,
    output logic                               do_load,
    output logic                               do_redo,
    output logic [ni_w-1:0]                    do_ni,
    output logic [k_w-1:0]                     do_k,
    output logic                               double,
    output logic                               iret_seen,
    output logic                               irq_start,
    output logic                               fault
);

    dsp16_ctrl_pkg::t_field_t t;
    dsp16_ctrl_pkg::t_field_t t_key;
    dsp16_ctrl_pkg::inc_sel_t inc_pre;
    logic                     step_pre;
    logic                     con_ok;
    logic                     is_iret;
    logic [2:0]               dest_r;  // {dau, xaau, yaau}
    logic [2:0]               dest_a;

    function automatic logic [2:0] dest_hit(input logic [2:0] code);
        logic [2:0] hit;
        hit[0] = code == dsp16_ctrl_pkg::yaau;
        hit[1] = code == dsp16_ctrl_pkg::xaau;
        hit[2] = code == dsp16_ctrl_pkg::dau;
        return hit;
    endfunction

    assign t = instr[15:11];
    // Goto, short imm and call don't care about bit 11
    assign t_key = (t[4:1] == dsp16_ctrl_pkg::op_goto_ja[4:1] ||
                    t[4:1] == dsp16_ctrl_pkg::op_short_imm[4:1] ||
                    t[4:1] == dsp16_ctrl_pkg::op_call_ja[4:1]) ? {t[4:1], 1'b0} : t;

    assign con_ok    = !flow.con_check || con_result;  // Skip result of previous word
    assign is_iret   = instr[10:8] == dsp16_ctrl_pkg::iret_code;
    assign iret_seen = !double && !irq_take && t == dsp16_ctrl_pkg::op_goto_b && is_iret;
    assign dest_r    = dest_hit(instr[9:7]);
    assign dest_a    = dest_hit({1'b0, instr[8:7]});

    // Post-modify from the low two bits
    always_comb begin
        step_pre = 1'b0;
        case (instr[1:0])
            2'd0: inc_pre = dsp16_ctrl_pkg::hold;  // *rN
            2'd1: inc_pre = dsp16_ctrl_pkg::inc;   // *rN++
            2'd2: inc_pre = dsp16_ctrl_pkg::dec;   // *rN--
            default: begin                         // *rN++j
                inc_pre  = dsp16_ctrl_pkg::hold;
                step_pre = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fields    <= '0;
            flow      <= '0;
            yaau      <= '0;
            load      <= '0;
            do_load   <= 1'b0;
            do_redo   <= 1'b0;
            do_ni     <= '0;
            do_k      <= '0;
            double    <= 1'b0;
            irq_start <= 1'b0;
            fault     <= 1'b0;
        end else if (cen) begin
            fields.long_imm <= instr;  // Valid in the second cycle of R=imm
            flow      <= '0;
            yaau      <= '0;
            load      <= '0;
            do_load   <= 1'b0;
            double    <= 1'b0;
            irq_start <= 1'b0;

            if (!double) begin
                fields.t_field   <= t;
                fields.r_field   <= instr[6:4];
                fields.rsel      <= instr[8:6];
                fields.a_field   <= 2'd0;
                fields.c_field   <= instr[4:0];
                fields.short_imm <= instr[8:0];
                fields.i_field   <= instr[11:0];

                if (irq_take) begin  // Jump to the vector instead of this word
                    flow.goto_ja <= 1'b1;
                    flow.pc_halt <= 1'b1;
                    double       <= 1'b1;
                    irq_start    <= 1'b1;
                end else begin
                    case (t_key)
                        dsp16_ctrl_pkg::op_goto_ja: begin
                            flow.goto_ja <= con_ok;
                            flow.pc_halt <= 1'b1;
                            double       <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::op_call_ja: begin
                            flow.call_ja <= con_ok;
                            flow.pc_halt <= 1'b1;
                            double       <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::op_goto_b: begin
                            flow.goto_b  <= con_ok || is_iret;  // iret never skipped
                            flow.pc_halt <= 1'b1;
                            double       <= 1'b1;
                            if (do_busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::op_short_imm: begin
                            load.short_load <= 1'b1;
                            fields.r_field  <= instr[11:9] ^ 3'b100;
                        end
                        dsp16_ctrl_pkg::op_at_r: begin
                            fields.a_field <= {1'b0, instr[10]};  // Target accumulator
                            flow.pc_halt   <= 1'b1;
                            double         <= 1'b1;
                        end
                        dsp16_ctrl_pkg::op_r_a0, dsp16_ctrl_pkg::op_r_a1: begin
                            fields.a_field <= {1'b1, instr[12]};
                            load.yaau_acc  <= dest_a[0];
                            load.xaau_acc  <= dest_a[1];
                            load.dau_acc   <= dest_a[2];
                            flow.pc_halt   <= 1'b1;
                            double         <= 1'b1;
                            if (dest_a == 3'd0) fault <= 1'b1;  // Port destinations
                        end
                        dsp16_ctrl_pkg::op_r_imm: begin
                            load.yaau_imm <= dest_r[0];
                            load.xaau_imm <= dest_r[1];
                            load.dau_imm  <= dest_r[2];
                            double        <= 1'b1;  // PC moves on to the immediate
                            if (dest_r == 3'd0 || do_busy) fault <= 1'b1;
                        end
                        dsp16_ctrl_pkg::op_r_ram, dsp16_ctrl_pkg::op_ram_r: begin
                            if (t == dsp16_ctrl_pkg::op_r_ram) begin
                                load.yaau_ram <= dest_r[0];
                                load.xaau_ram <= dest_r[1];
                                load.dau_ram  <= dest_r[2];
                                if (dest_r == 3'd0) fault <= 1'b1;
                            end
                            yaau.ram_we    <= t == dsp16_ctrl_pkg::op_ram_r;
                            yaau.post_load <= 1'b1;
                            yaau.inc_sel   <= inc_pre;
                            yaau.step_sel  <= step_pre;
                            yaau.ksel      <= 1'b0;  // j step only
                            yaau.y_field   <= instr[3:2];
                            flow.pc_halt   <= 1'b1;
                            double         <= 1'b1;
                        end
                        dsp16_ctrl_pkg::op_con_skip: begin
                            if (!instr[10]) flow.con_check <= 1'b1;
                            else fault <= 1'b1;  // icall form
                        end
                        dsp16_ctrl_pkg::op_do: begin
                            do_load <= 1'b1;
                            do_k    <= k_w'(instr[6:0]);
                            if (instr[10:7] == 4'd0) begin  // redo
                                do_redo      <= 1'b1;
                                flow.pc_halt <= 1'b1;
                                double       <= 1'b1;
                            end else begin
                                do_redo <= 1'b0;
                                do_ni   <= ni_w'(instr[10:7] - 4'd1);
                            end
                        end
                        default: fault <= 1'b1;
                    endcase
                end
            end

            // Extra cycle at the end of the first pass and of the whole loop
            if (do_first_end || do_out) begin
                flow.pc_halt <= 1'b1;
                double       <= 1'b1;
                if (do_out) do_redo <= 1'b0;
            end
        end
    end

endmodule

// ==== design/ctrl_do_loop.sv ====
////////////////////////////////////////
// DO/REDO counter. Tracks the body index and the
// remaining passes, and flags the end of the first
// pass and the last instruction of the loop.
////////////////////////////////////////
module ctrl_do_loop #(
    parameter int ni_w = 4,
    parameter int k_w  = 7
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    input  logic            do_load,
    input  logic            do_redo,
    input  logic [ni_w-1:0] do_ni,   // Body length minus one
    input  logic [k_w-1:0]  do_k,
    input  logic            double,
    output logic [ni_w-1:0] do_pc,
    output logic            do_start,
    output logic            do_busy,
    output logic            do_first_end,
    output logic            do_out
);

    logic [ni_w-1:0] idx;
    logic [k_w-1:0]  k_cnt;
    logic            pass_end;
    logic            short_body;

    assign pass_end   = idx == do_ni;
    assign short_body = !do_redo && do_ni == '0;  // One-word body ends on load
    assign do_busy    = k_cnt != '0;
    assign do_pc      = idx;

    assign do_first_end = !double && !do_redo &&
                          (do_load ? short_body : do_busy && pass_end && k_cnt == do_k);
    assign do_out       = !double && do_busy && pass_end && k_cnt == k_w'(1);
    assign do_start     = do_first_end || (do_redo && do_load);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx   <= '0;
            k_cnt <= '0;
        end else if (cen) begin
            if (do_load) begin
                // DO body word 0 is decoded in the load cycle
                idx   <= (do_redo || short_body) ? '0 : ni_w'(1);
                k_cnt <= short_body ? do_k - k_w'(1) : do_k;
            end else if (!double && do_busy) begin
                idx <= pass_end ? '0 : idx + ni_w'(1);
                if (pass_end) k_cnt <= k_cnt - k_w'(1);
            end
        end
    end

endmodule

// ==== design/ctrl_irq.sv ====
////////////////////////////////////////
// Interrupt acceptance. Takes irq on a safe word
// outside a loop, holds iack through the handler
// and drops it after iret and one safe word.
////////////////////////////////////////
module ctrl_irq (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cen,
    input  logic [dsp16_ctrl_pkg::instr_w-1:0] instr,
    input  logic                               irq,
    input  logic                               iret_seen,
    input  logic                               double,
    input  logic                               do_busy,
    output logic                               irq_take,
    output logic                               iack
);

    dsp16_ctrl_pkg::t_field_t t;
    logic                     irq_ok;
    logic                     clr_pend;  // iret decoded, waiting for a safe word

    assign t = instr[15:11];

    // Branches, skips and DO must not be replaced by the vector jump
    assign irq_ok = !(t[4:1] == dsp16_ctrl_pkg::op_goto_ja[4:1] ||
                      t[4:1] == dsp16_ctrl_pkg::op_call_ja[4:1] ||
                      t == dsp16_ctrl_pkg::op_goto_b ||
                      t == dsp16_ctrl_pkg::op_con_skip ||
                      t == dsp16_ctrl_pkg::op_do);

    assign irq_take = irq && irq_ok && !iack && !double && !do_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iack     <= 1'b0;
            clr_pend <= 1'b0;
        end else if (cen && !double) begin
            if (irq_take) begin
                iack     <= 1'b1;
                clr_pend <= 1'b0;
            end else if (iret_seen) begin
                clr_pend <= 1'b1;
            end else if (irq_ok && clr_pend) begin
                iack     <= 1'b0;
                clr_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== design/dsp16_ctrl.sv ====
////////////////////////////////////////
// DSP16 control unit top level.
// Takes one ROM word per cen cycle and gives
// registered strobes and fields one cen cycle later.
////////////////////////////////////////
module dsp16_ctrl #(
    parameter int ni_w = 4,  // Loop body length
    parameter int k_w  = 7   // Repeat count
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cen,
    input  logic [dsp16_ctrl_pkg::instr_w-1:0]   instr,
    input  logic                                 con_result,
    input  logic                                 irq,
    output dsp16_ctrl_pkg::instr_fields_t        fields,
    output dsp16_ctrl_pkg::flow_ctrl_t           flow,
    output dsp16_ctrl_pkg::yaau_ctrl_t           yaau,
    output dsp16_ctrl_pkg::load_ctrl_t           load,
    output logic [ni_w-1:0]                      do_pc,
    output logic                                 do_start,
    output logic                                 do_out,
    output logic                                 do_redo,
    output logic                                 irq_start,
    output logic                                 iack,
    output logic                                 fault
);

    logic            irq_take;
    logic            iret_seen;
    logic            double;
    logic            do_load;
    logic            do_busy;
    logic            do_first_end;
    logic [ni_w-1:0] do_ni;
    logic [k_w-1:0]  do_k;

    ctrl_decode #(.ni_w(ni_w), .k_w(k_w)) decode_i (
        .clk, .rst, .cen, .instr, .con_result,
        .irq_take, .do_busy, .do_first_end, .do_out,
        .fields, .flow, .yaau, .load,
        .do_load, .do_redo, .do_ni, .do_k,
        .double, .iret_seen, .irq_start, .fault
    );

    ctrl_do_loop #(.ni_w(ni_w), .k_w(k_w)) do_loop_i (
        .clk, .rst, .cen,
        .do_load, .do_redo, .do_ni, .do_k, .double,
        .do_pc, .do_start, .do_busy, .do_first_end, .do_out
    );

    ctrl_irq irq_i (
        .clk, .rst, .cen, .instr, .irq,
        .iret_seen, .double, .do_busy,
        .irq_take, .iack
    );

endmodule

// ==== design/dsp16_ctrl_pkg.sv ====
////////////////////////////////////////
// Shared definitions for the DSP16 control unit:
// instruction field widths, T opcode codes and the
// packed control structs on the module ports.
// Reference everything by scoped name.
////////////////////////////////////////
package dsp16_ctrl_pkg;

    localparam int instr_w = 16;

    typedef logic [4:0] t_field_t;  // Bits 15:11

    // T codes of the kept groups
    localparam t_field_t op_goto_ja   = 5'b00000;  // Also 5'b00001
    localparam t_field_t op_short_imm = 5'b00010;  // Also 5'b00011
    localparam t_field_t op_call_ja   = 5'b10000;  // Also 5'b10001
    localparam t_field_t op_goto_b    = 5'b11000;
    localparam t_field_t op_at_r      = 5'b01000;
    localparam t_field_t op_r_a0      = 5'b01001;
    localparam t_field_t op_r_a1      = 5'b01011;
    localparam t_field_t op_r_imm     = 5'b01010;
    localparam t_field_t op_r_ram     = 5'b01111;
    localparam t_field_t op_ram_r     = 5'b01100;
    localparam t_field_t op_con_skip  = 5'b11010;
    localparam t_field_t op_do        = 5'b01110;

    localparam logic [2:0] iret_code = 3'd1;  // goto B sub-code in bits 10:8

    // Post-modify of the Y pointer
    typedef enum logic [1:0] {
        dec  = 2'd0,
        hold = 2'd1,
        inc  = 2'd2
    } inc_sel_t;

    // Destination unit of a register load
    typedef enum logic [2:0] {
        yaau = 3'd0,
        xaau = 3'd1,
        dau  = 3'd2
    } dest_t;

    typedef struct packed {
        logic goto_ja;
        logic goto_b;
        logic call_ja;
        logic pc_halt;
        logic con_check;
    } flow_ctrl_t;

    typedef struct packed {
        logic     post_load;
        logic     ram_we;
        inc_sel_t inc_sel;
        logic     step_sel;
        logic     ksel;
        logic [1:0] y_field;
    } yaau_ctrl_t;

    typedef struct packed {
        logic yaau_imm;
        logic xaau_imm;
        logic dau_imm;
        logic yaau_ram;
        logic xaau_ram;
        logic dau_ram;
        logic yaau_acc;
        logic xaau_acc;
        logic dau_acc;
        logic short_load;
    } load_ctrl_t;

    typedef struct packed {
        t_field_t    t_field;
        logic [2:0]  r_field;
        logic [2:0]  rsel;
        logic [1:0]  a_field;
        logic [4:0]  c_field;
        logic [8:0]  short_imm;
        logic [11:0] i_field;
        logic [15:0] long_imm;
    } instr_fields_t;

endpackage

// ==== dsp16_ctrl.f ====
design/dsp16_ctrl_pkg.sv
design/ctrl_decode.sv
design/ctrl_do_loop.sv
design/ctrl_irq.sv
design/dsp16_ctrl.sv
verification/dsp16_ctrl_asserts.sv
verification/tb_dsp16_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the DSP16 control unit testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_dsp16_ctrl \
    -f dsp16_ctrl.f
./obj_dir/Vtb_dsp16_ctrl > sim.log 2>&1 || true
cat sim.log
if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// ==== verification/dsp16_ctrl_asserts.sv ====
////////////////////////////////////////
// Concurrent checks on the decoder outputs.
// Bound into ctrl_decode at the end of this file.
////////////////////////////////////////
module dsp16_ctrl_asserts (
    input logic                       clk,
    input logic                       rst,
    input logic                       cen,
    input logic                       double,
    input logic                       fault,
    input dsp16_ctrl_pkg::flow_ctrl_t flow,
    input dsp16_ctrl_pkg::yaau_ctrl_t yaau,
    input dsp16_ctrl_pkg::load_ctrl_t load
);

    // Second cycle of a two-cycle word decodes nothing
    quiet_after_double: assert property (@(posedge clk) disable iff (rst)
        (cen && double) |=> (flow == '0 && yaau == '0 && load == '0))
        else $error("strobes set in the cycle after a two-cycle word");

    we_needs_post_load: assert property (@(posedge clk) disable iff (rst)
        yaau.ram_we |-> yaau.post_load)
        else $error("ram_we without post_load");

    fault_sticky: assert property (@(posedge clk)
        $fell(fault) |-> rst)
        else $error("fault cleared without reset");

endmodule

bind ctrl_decode dsp16_ctrl_asserts decode_asserts_i (
    .clk, .rst, .cen, .double, .fault, .flow, .yaau, .load
);

// ==== verification/tb_dsp16_ctrl.sv ====
////////////////////////////////////////
// Directed testbench for the DSP16 control unit.
// Each test task feeds ROM words and checks the
// registered outputs one cycle later.
////////////////////////////////////////
module tb_dsp16_ctrl;

    localparam logic [15:0] nop_word = 16'h1000;  // Short immediate, one cycle

    logic        clk;
    logic        rst;
    logic        cen;
    logic [15:0] instr;
    logic        con_result;
    logic        irq;
    logic [3:0]  do_pc;
    logic        do_start;
    logic        do_out;
    logic        do_redo;
    logic        irq_start;
    logic        iack;
    logic        fault;
    int          errors;
    int          checks;
    int          tests;
    int          seed;
    dsp16_ctrl_pkg::instr_fields_t fields;
    dsp16_ctrl_pkg::flow_ctrl_t    flow;
    dsp16_ctrl_pkg::yaau_ctrl_t    yaau;
    dsp16_ctrl_pkg::load_ctrl_t    load;

    dsp16_ctrl #(.ni_w(4), .k_w(7)) dsp16_ctrl_i (
        .clk, .rst, .cen, .instr, .con_result, .irq,
        .fields, .flow, .yaau, .load, .do_pc, .do_start,
        .do_out, .do_redo, .irq_start, .iack, .fault
    );

    always #4 clk = ~clk;

    task automatic present_word(input logic [15:0] word);
        instr = word;
        @(posedge clk);
        #1;  // Outputs of this word are now settled
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic check_flow(input dsp16_ctrl_pkg::flow_ctrl_t exp, input string what);
        checks++;
        if (flow !== exp) begin
            errors++;
            $display("** Error @%0t: %s flow %b, expected %b", $time, what, flow, exp);
        end
    endtask

    task automatic check_yaau(input dsp16_ctrl_pkg::yaau_ctrl_t exp, input string what);
        checks++;
        if (yaau !== exp) begin
            errors++;
            $display("** Error @%0t: %s yaau %b, expected %b", $time, what, yaau, exp);
        end
    endtask

    task automatic check_load(input dsp16_ctrl_pkg::load_ctrl_t exp, input string what);
        checks++;
        if (load !== exp) begin
            errors++;
            $display("** Error @%0t: %s load %b, expected %b", $time, what, load, exp);
        end
    endtask

    task automatic check_fields(input dsp16_ctrl_pkg::instr_fields_t exp, input string what);
        checks++;
        if (fields !== exp) begin
            errors++;
            $display("** Error @%0t: %s fields %h, expected %h", $time, what, fields, exp);
        end
    endtask

    // Single flags, do_pc and counts
    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @%0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_idle(input string what);
        check_flow('0, what);
        check_yaau('0, what);
        check_load('0, what);
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("%s: %0d errors", name, errors - e0);
    endtask

    function automatic dsp16_ctrl_pkg::instr_fields_t expected_fields(input logic [15:0] w);
        dsp16_ctrl_pkg::instr_fields_t f;
        f.t_field   = w[15:11];
        f.r_field   = w[6:4];
        f.rsel      = w[8:6];
        f.a_field   = 2'd0;
        f.c_field   = w[4:0];
        f.short_imm = w[8:0];
        f.i_field   = w[11:0];
        f.long_imm  = w;
        return f;
    endfunction

    // src 0 imm, 1 ram, 2 acc; d 0 yaau, 1 xaau, 2 dau
    function automatic dsp16_ctrl_pkg::load_ctrl_t dest_load(input int src, input int d);
        return dsp16_ctrl_pkg::load_ctrl_t'(10'b1000000000 >> (3 * src + d));
    endfunction

    function automatic dsp16_ctrl_pkg::yaau_ctrl_t expected_yaau(
        input logic [1:0] mode, input logic [1:0] y, input logic we);
        dsp16_ctrl_pkg::yaau_ctrl_t exp;
        exp           = '0;
        exp.post_load = 1'b1;
        exp.ram_we    = we;
        exp.y_field   = y;
        case (mode)
            2'd0: exp.inc_sel = dsp16_ctrl_pkg::hold;
            2'd1: exp.inc_sel = dsp16_ctrl_pkg::inc;
            2'd2: exp.inc_sel = dsp16_ctrl_pkg::dec;
            default: begin
                exp.inc_sel  = dsp16_ctrl_pkg::hold;
                exp.step_sel = 1'b1;
            end
        endcase
        return exp;
    endfunction

    task automatic test_reset_freeze();
        int e0;
        e0 = errors;
        check_idle("reset");
        check_fields('0, "reset");
        check_word(16'(iack), 16'd0, "reset iack");
        check_word(16'(fault), 16'd0, "reset fault");
        check_word(16'(do_redo), 16'd0, "reset do_redo");
        cen = 1'b0;
        irq = 1'b1;
        present_word(nop_word);  // Interruptible word with irq high
        check_idle("cen low");
        check_word(16'(iack), 16'd0, "cen low iack");
        present_word({dsp16_ctrl_pkg::op_goto_ja, 11'h055});
        check_idle("cen low");
        check_fields('0, "cen low");
        check_word(16'(iack), 16'd0, "cen low iack");
        cen = 1'b1;
        irq = 1'b0;
        finish_test("reset and freeze", e0);
    endtask

    task automatic test_branches();
        int                            e0;
        logic [15:0]                   w;
        logic [15:0]                   rnd;
        dsp16_ctrl_pkg::instr_fields_t exp_f;
        e0 = errors;
        w = {dsp16_ctrl_pkg::op_goto_ja, 11'h123};
        present_word(w);
        check_flow(5'b10010, "goto ja");  // goto_ja, goto_b, call_ja, pc_halt, con_check
        check_fields(expected_fields(w), "goto ja");
        rnd = 16'($random(seed));
        present_word(rnd);  // Second cycle, word ignored
        exp_f          = expected_fields(w);
        exp_f.long_imm = rnd;
        check_idle("after goto");
        check_fields(exp_f, "after goto");
        present_word({dsp16_ctrl_pkg::op_call_ja, 11'h456});
        check_flow(5'b00110, "call ja");
        present_word(16'($random(seed)));
        check_idle("after call");
        for (int c = 0; c < 2; c++) begin
            present_word({dsp16_ctrl_pkg::op_con_skip, 11'h012});
            check_flow(5'b00001, "con skip");
            con_result = 1'(c);
            present_word({dsp16_ctrl_pkg::op_goto_ja, 11'h200});
            check_flow(c == 0 ? 5'b00010 : 5'b10010, "goto after skip");
            present_word(nop_word);
        end
        con_result = 1'b0;
        present_word({dsp16_ctrl_pkg::op_con_skip, 11'h012});
        present_word({dsp16_ctrl_pkg::op_goto_b, dsp16_ctrl_pkg::iret_code, 8'h00});
        check_flow(5'b01010, "iret after false skip");
        present_word(nop_word);
        finish_test("branches", e0);
    endtask

    task automatic test_immediates();
        int                            e0;
        logic [15:0]                   w;
        logic [15:0]                   rnd;
        dsp16_ctrl_pkg::instr_fields_t exp_f;
        e0 = errors;
        repeat (3) begin
            rnd = 16'($random(seed));
            w   = {4'b0001, rnd[11:0]};
            present_word(w);
            exp_f         = expected_fields(w);
            exp_f.r_field = w[11:9] ^ 3'b100;  // Top register bit inverted
            check_flow('0, "short imm");
            check_load(dest_load(3, 0), "short imm");  // Shift lands on short_load
            check_fields(exp_f, "short imm");
        end
        for (int d = 0; d < 3; d++) begin
            w = {dsp16_ctrl_pkg::op_r_imm, 1'b0, 3'(d), 7'h00};
            present_word(w);
            check_flow('0, "long imm");
            check_load(dest_load(0, d), "long imm");
            rnd = 16'($random(seed));
            present_word(rnd);  // The immediate itself
            exp_f          = expected_fields(w);
            exp_f.long_imm = rnd;
            check_idle("long imm value");
            check_fields(exp_f, "long imm value");
        end
        finish_test("immediates", e0);
    endtask

    task automatic test_ram();
        int         e0;
        logic [1:0] y;
        e0 = errors;
        for (int m = 0; m < 4; m++) begin
            y = 2'(m) ^ 2'b10;
            present_word({dsp16_ctrl_pkg::op_ram_r, 7'h00, y, 2'(m)});
            check_yaau(expected_yaau(2'(m), y, 1'b1), "ram write");
            check_flow(5'b00010, "ram write");
            check_load('0, "ram write");
            present_word(nop_word);
            check_idle("after ram write");
            present_word({dsp16_ctrl_pkg::op_r_ram, 1'b0, 3'd1, 3'b000, y, 2'(m)});
            check_yaau(expected_yaau(2'(m), y, 1'b0), "ram read");
            check_load(dest_load(1, 1), "ram read");
            present_word(nop_word);
        end
        finish_test("ram access", e0);
    endtask

    task automatic test_do_loop();
        int         e0;
        int         n;
        int         words;
        int         outs;
        int         starts;
        logic [3:0] exp_idx;
        e0      = errors;
        n       = 0;
        words   = 0;
        outs    = 0;
        starts  = 0;
        exp_idx = 4'd0;
        present_word({dsp16_ctrl_pkg::op_do, 4'd2, 7'd3});  // ni 2, k 3
        while (words < 6 && n < 40) begin
            n++;
            if (do_out) outs++;
            if (do_start) starts++;
            if (flow.pc_halt) begin
                present_word(nop_word);  // Boundary cycle
            end else begin
                check_word(16'(do_pc), 16'(exp_idx), "loop index");
                irq = words > 0;  // Held off while the loop is busy
                present_word({4'b0001, 12'(words)});
                words++;
                exp_idx = (exp_idx == 4'd1) ? 4'd0 : 4'd1;
            end
        end
        irq = 1'b0;
        if (words < 6) begin
            errors++;
            $display("Loop body did not finish within %0d cycles", n);
        end
        repeat (4) begin
            if (do_out) outs++;
            if (do_start) starts++;
            present_word(nop_word);
        end
        check_word(16'(outs), 16'd1, "do_out pulses");
        check_word(16'(starts), 16'd1, "do_start pulses");
        check_word(16'(iack), 16'd0, "irq inside loop");
        check_word(16'(fault), 16'd0, "fault after loop");
        finish_test("do loop", e0);
    endtask

    task automatic test_loop_fault();
        int e0;
        e0 = errors;
        present_word({dsp16_ctrl_pkg::op_do, 4'd2, 7'd3});
        present_word(nop_word);
        present_word({dsp16_ctrl_pkg::op_goto_ja, 11'h040});  // Branch in the body
        check_word(16'(fault), 16'd1, "goto in loop");
        present_word(nop_word);
        check_word(16'(fault), 16'd1, "fault held");
        apply_reset();
        check_word(16'(fault), 16'd0, "fault after reset");
        finish_test("loop fault", e0);
    endtask

    task automatic test_irq();
        int          e0;
        logic [15:0] w;
        e0  = errors;
        w   = {5'b00010, 11'h0f0};
        irq = 1'b1;
        present_word({dsp16_ctrl_pkg::op_goto_ja, 11'h100});  // Not interruptible
        check_word(16'(irq_start), 16'd0, "irq on goto");
        present_word(nop_word);
        check_word(16'(iack), 16'd0, "irq in second cycle");
        present_word(w);
        check_flow(5'b10010, "irq taken");
        check_load('0, "irq taken");
        check_word(16'(irq_start), 16'd1, "irq_start");
        check_word(16'(iack), 16'd1, "iack set");
        present_word(nop_word);
        present_word(w);  // Second irq while iack is high
        check_load(dest_load(3, 0), "second irq");
        check_word(16'(irq_start), 16'd0, "second irq_start");
        irq = 1'b0;
        present_word({dsp16_ctrl_pkg::op_goto_b, dsp16_ctrl_pkg::iret_code, 8'h00});
        check_word(16'(iack), 16'd1, "iack at iret");
        present_word(nop_word);
        check_word(16'(iack), 16'd1, "iack after iret");
        present_word(nop_word);
        check_word(16'(iack), 16'd0, "iack cleared");
        finish_test("interrupts", e0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cen        = 1'b1;
        instr      = nop_word;
        con_result = 1'b0;
        irq        = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        seed       = 32'heaf5;
        apply_reset();
        test_reset_freeze();
        test_branches();
        test_immediates();
        test_ram();
        test_do_loop();
        test_loop_fault();
        test_irq();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
